// ==== Makefile ====
SOURCES := $(wildcard include/*.svh hdl/*.sv verification/*.sv)

obj_dir/Vcommit_tb: filelist.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module commit_tb -f filelist.f

.PHONY: run clean

run: obj_dir/Vcommit_tb
	./obj_dir/Vcommit_tb

clean:
	rm -rf obj_dir

// ==== filelist.f ====
+incdir+include
hdl/pipeline_pkg.sv
hdl/wb_stage.sv
hdl/commit_ctrl.sv
hdl/csr_excp.sv
hdl/regfile.sv
hdl/commit_top.sv
verification/commit_tb.sv

// ==== hdl/commit_ctrl.sv ====
`include "pipeline_params.svh"

module commit_ctrl
    import pipeline_pkg::*;
(
    input  wb_slot_t  wb_slot0_i,
    input  wb_slot_t  wb_slot1_i,

    input  logic      dispatch_stallreq_i,
    input  logic [1:0] mem_stallreq_i,

    output stall_t    stall_o,
    output logic      flush_o,

    output wb_reg_t   rf_w0_o,
    output wb_reg_t   rf_w1_o,

    output commit_t   commit0_o,
    output commit_t   commit1_o,

    output excp_rec_t excp_rec_o,
    output logic      ertn_o
);

    logic      slot0_ok;
    logic      slot0_ertn;
    logic      retire1;
    logic      slot0_excp;
    logic      slot1_excp;
    logic      sel_slot1;
    logic      any_excp;
    excp_vec_t sel_num;
    word_t     sel_pc;
    word_t     sel_wdata;
    logic [3:0] cause;
    ecode_t    ecode;
    esubcode_t esubcode;
    logic      has_va;
    logic      va_from_pc;
    logic      tlb;
    logic      refill;
    word_t     bad_va;

    always_comb begin
        if (mem_stallreq_i[0] | mem_stallreq_i[1]) begin
            stall_o = 5'b11110;
        end else if (dispatch_stallreq_i) begin
            stall_o = 5'b11100;
        end else begin
            stall_o = 5'b00000;
        end
    end

    assign slot0_ok   = wb_slot0_i.valid & ~wb_slot0_i.excp;
    assign slot0_ertn = slot0_ok & (wb_slot0_i.aluop == `EXE_ERTN_OP);
    assign retire1    = wb_slot1_i.valid & ~wb_slot1_i.excp & slot0_ok & ~slot0_ertn;

    assign ertn_o  = slot0_ertn;
    assign flush_o = excp_rec_o.valid | slot0_ertn;

    always_comb begin
        rf_w0_o    = wb_slot0_i.wb_reg;
        rf_w0_o.we = slot0_ok & wb_slot0_i.wb_reg.we;
        rf_w1_o    = wb_slot1_i.wb_reg;
        rf_w1_o.we = retire1 & wb_slot1_i.wb_reg.we;
    end

    assign commit0_o = '{valid: slot0_ok, pc: wb_slot0_i.wb_reg.pc};
    assign commit1_o = '{valid: retire1, pc: wb_slot1_i.wb_reg.pc};

    // slot 1 behind an ERTN is squashed along with its exception
    assign slot0_excp = wb_slot0_i.valid & wb_slot0_i.excp;
    assign slot1_excp = wb_slot1_i.valid & wb_slot1_i.excp & ~slot0_ertn;
    assign sel_slot1  = ~slot0_excp & slot1_excp;
    assign any_excp   = slot0_excp | slot1_excp;

    assign sel_num   = sel_slot1 ? wb_slot1_i.excp_num     : wb_slot0_i.excp_num;
    assign sel_pc    = sel_slot1 ? wb_slot1_i.wb_reg.pc    : wb_slot0_i.wb_reg.pc;
    assign sel_wdata = sel_slot1 ? wb_slot1_i.wb_reg.wdata : wb_slot0_i.wb_reg.wdata;

    // lowest set cause bit
    always_comb begin
        cause = `CAUSE_INT;
        for (int i = 15; i >= 0; i--) begin
            if (sel_num[i]) begin
                cause = 4'(i);
            end
        end
    end

    always_comb begin
        ecode      = `ECODE_INT;
        esubcode   = `ESUBCODE_ADEF;
        has_va     = 1'b0;
        va_from_pc = 1'b0;
        tlb        = 1'b0;
        refill     = 1'b0;
        case (cause)
            `CAUSE_INT:    ecode = `ECODE_INT;
            `CAUSE_ADEF:   begin ecode = `ECODE_ADEF; has_va = 1'b1; va_from_pc = 1'b1; end
            `CAUSE_TLBR_F: begin
                ecode = `ECODE_TLBR;
                has_va = 1'b1;
                va_from_pc = 1'b1;
                tlb = 1'b1;
                refill = 1'b1;
            end
            `CAUSE_PIF:    begin ecode = `ECODE_PIF; has_va = 1'b1; va_from_pc = 1'b1; tlb = 1'b1; end
            `CAUSE_PPI_F:  begin ecode = `ECODE_PPI; has_va = 1'b1; va_from_pc = 1'b1; tlb = 1'b1; end
            `CAUSE_SYS:    ecode = `ECODE_SYS;
            `CAUSE_BRK:    ecode = `ECODE_BRK;
            `CAUSE_INE:    ecode = `ECODE_INE;
            `CAUSE_IPE:    ecode = `ECODE_IPE;
            `CAUSE_ALE:    begin ecode = `ECODE_ALE; has_va = 1'b1; end
            `CAUSE_ADEM:   begin ecode = `ECODE_ADEF; esubcode = `ESUBCODE_ADEM; has_va = 1'b1; end
            `CAUSE_TLBR_M: begin ecode = `ECODE_TLBR; has_va = 1'b1; tlb = 1'b1; refill = 1'b1; end
            `CAUSE_PME:    begin ecode = `ECODE_PME; has_va = 1'b1; tlb = 1'b1; end
            `CAUSE_PPI_M:  begin ecode = `ECODE_PPI; has_va = 1'b1; tlb = 1'b1; end
            `CAUSE_PIS:    begin ecode = `ECODE_PIS; has_va = 1'b1; tlb = 1'b1; end
            `CAUSE_PIL:    begin ecode = `ECODE_PIL; has_va = 1'b1; tlb = 1'b1; end
            default:       ecode = `ECODE_INT;
        endcase
    end

    // memory-side faults carry the address in wdata
    assign bad_va = !has_va ? '0 : (va_from_pc ? sel_pc : sel_wdata);

    always_comb begin
        excp_rec_o = '0;
        if (any_excp) begin
            excp_rec_o.valid     = 1'b1;
            excp_rec_o.tlbrefill = refill;
            excp_rec_o.tlb       = tlb;
            excp_rec_o.va_error  = has_va;
            excp_rec_o.ecode     = ecode;
            excp_rec_o.esubcode  = esubcode;
            excp_rec_o.era       = sel_pc;
            excp_rec_o.bad_va    = bad_va;
            excp_rec_o.vppn      = tlb ? bad_va[31:13] : '0;
        end
    end

    // an excepting instruction and everything younger stays uncommitted
    always_comb begin
        a_no_commit_on_excp: assert final (!(excp_rec_o.valid &&
            (commit1_o.valid || (commit0_o.valid && !sel_slot1))));
    end

endmodule

// ==== hdl/commit_top.sv ====
module commit_top
    import pipeline_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  wb_slot_t   mem_slot0_i,
    input  wb_slot_t   mem_slot1_i,
    input  logic       dispatch_stallreq_i,
    input  logic [1:0] mem_stallreq_i,

    input  reg_addr_t  rf_raddr0_i,
    input  reg_addr_t  rf_raddr1_i,

    output stall_t     stall_o,
    output logic       flush_o,
    output word_t      redirect_pc_o,

    output commit_t    commit0_o,
    output commit_t    commit1_o,

    output csr_state_t csr_o,

    output word_t      rf_rdata0_o,
    output word_t      rf_rdata1_o
);

    wb_slot_t  wb_slot0;
    wb_slot_t  wb_slot1;
    wb_reg_t   rf_w0;
    wb_reg_t   rf_w1;
    excp_rec_t excp_rec;
    logic      ertn;

    wb_stage u_wb_stage (
        .clk         (clk),
        .rst         (rst),
        .mem_slot0_i (mem_slot0_i),
        .mem_slot1_i (mem_slot1_i),
        .stall_i     (stall_o),
        .flush_i     (flush_o),
        .wb_slot0_o  (wb_slot0),
        .wb_slot1_o  (wb_slot1)
    );

    commit_ctrl u_commit_ctrl (
        .wb_slot0_i          (wb_slot0),
        .wb_slot1_i          (wb_slot1),
        .dispatch_stallreq_i (dispatch_stallreq_i),
        .mem_stallreq_i      (mem_stallreq_i),
        .stall_o             (stall_o),
        .flush_o             (flush_o),
        .rf_w0_o             (rf_w0),
        .rf_w1_o             (rf_w1),
        .commit0_o           (commit0_o),
        .commit1_o           (commit1_o),
        .excp_rec_o          (excp_rec),
        .ertn_o              (ertn)
    );

    csr_excp u_csr_excp (
        .clk           (clk),
        .rst           (rst),
        .excp_rec_i    (excp_rec),
        .ertn_i        (ertn),
        .csr_o         (csr_o),
        .redirect_pc_o (redirect_pc_o)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        .w0_i     (rf_w0),
        .w1_i     (rf_w1),
        .raddr0_i (rf_raddr0_i),
        .raddr1_i (rf_raddr1_i),
        .rdata0_o (rf_rdata0_o),
        .rdata1_o (rf_rdata1_o)
    );

endmodule

// ==== hdl/csr_excp.sv ====
`include "pipeline_params.svh"

module csr_excp
    import pipeline_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    input  excp_rec_t  excp_rec_i,
    input  logic       ertn_i,

    output csr_state_t csr_o,
    output word_t      redirect_pc_o
);

    csr_state_t csr_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            csr_q <= '0;
        end else if (excp_rec_i.valid) begin
            // save old mode to prmd and enter kernel with interrupts off
            csr_q.prmd_pplv <= csr_q.crmd_plv;
            csr_q.prmd_pie  <= csr_q.crmd_ie;
            csr_q.crmd_plv  <= 2'd0;
            csr_q.crmd_ie   <= 1'b0;
            csr_q.era       <= excp_rec_i.era;
            csr_q.ecode     <= excp_rec_i.ecode;
            csr_q.esubcode  <= excp_rec_i.esubcode;
            if (excp_rec_i.va_error) begin
                csr_q.badv <= excp_rec_i.bad_va;
            end
            if (excp_rec_i.tlb) begin
                csr_q.vppn <= excp_rec_i.vppn;
            end
        end else if (ertn_i) begin
            csr_q.crmd_plv <= csr_q.prmd_pplv;
            csr_q.crmd_ie  <= csr_q.prmd_pie;
        end
    end

    assign csr_o = csr_q;

    always_comb begin
        if (excp_rec_i.valid) begin
            redirect_pc_o = excp_rec_i.tlbrefill ? `TLBRENTRY_ADDR : `EENTRY_ADDR;
        end else if (ertn_i) begin
            redirect_pc_o = csr_q.era;
        end else begin
            redirect_pc_o = '0;
        end
    end

    // slot 0 ertn retires only without an exception anywhere older
    a_excp_ertn_excl: assert property (@(posedge clk) disable iff (rst)
        !(excp_rec_i.valid && ertn_i));

endmodule

// ==== hdl/pipeline_pkg.sv ====
`include "pipeline_params.svh"

package pipeline_pkg;

    typedef logic [`REG_BUS_W-1:0] word_t;
    typedef logic [4:0]            reg_addr_t;
    typedef logic [5:0]            ecode_t;
    typedef logic [8:0]            esubcode_t;
    typedef logic [18:0]           vppn_t;
    typedef logic [7:0]            aluop_t;
    typedef logic [15:0]           excp_vec_t;
    // fetch is bit 0, writeback is bit 4
    typedef logic [4:0]            stall_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
        word_t     pc;
    } wb_reg_t;

    typedef struct packed {
        logic      valid;
        aluop_t    aluop;
        logic      excp;
        excp_vec_t excp_num;
        wb_reg_t   wb_reg;
    } wb_slot_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } commit_t;

    typedef struct packed {
        logic      valid;
        logic      tlbrefill;
        logic      tlb;
        logic      va_error;
        ecode_t    ecode;
        esubcode_t esubcode;
        word_t     era;
        word_t     bad_va;
        vppn_t     vppn;
    } excp_rec_t;

    typedef struct packed {
        logic [1:0] crmd_plv;
        logic       crmd_ie;
        logic [1:0] prmd_pplv;
        logic       prmd_pie;
        word_t      era;
        ecode_t     ecode;
        esubcode_t  esubcode;
        word_t      badv;
        vppn_t      vppn;
    } csr_state_t;

endpackage

// ==== hdl/regfile.sv ====
module regfile
    import pipeline_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  wb_reg_t   w0_i,
    input  wb_reg_t   w1_i,

    input  reg_addr_t raddr0_i,
    input  reg_addr_t raddr1_i,
    output word_t     rdata0_o,
    output word_t     rdata1_o
);

    word_t regs [32];

    // r0 is cleared at reset and never written afterwards
    always_ff @(posedge clk) begin
        if (rst) begin
            regs[0] <= '0;
        end else begin
            if (w0_i.we && (w0_i.waddr != '0)) begin
                regs[w0_i.waddr] <= w0_i.wdata;
            end
            // younger slot last, so it wins a same-register write
            if (w1_i.we && (w1_i.waddr != '0)) begin
                regs[w1_i.waddr] <= w1_i.wdata;
            end
        end
    end

    assign rdata0_o = regs[raddr0_i];
    assign rdata1_o = regs[raddr1_i];

    a_r0_zero: assert property (@(posedge clk) disable iff (rst)
        (raddr0_i == '0) |-> (rdata0_o == '0));

endmodule

// ==== hdl/wb_stage.sv ====
module wb_stage
    import pipeline_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  wb_slot_t mem_slot0_i,
    input  wb_slot_t mem_slot1_i,

    input  stall_t   stall_i,
    input  logic     flush_i,

    output wb_slot_t wb_slot0_o,
    output wb_slot_t wb_slot1_o
);

    logic     bubble;
    wb_slot_t slot0_q;
    wb_slot_t slot1_q;

    // memory stage held or pipeline flushed
    assign bubble = flush_i | stall_i[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            slot0_q.valid <= 1'b0;
            slot1_q.valid <= 1'b0;
        end else if (bubble) begin
            slot0_q.valid <= 1'b0;
            slot1_q.valid <= 1'b0;
        end else begin
            slot0_q.valid <= mem_slot0_i.valid;
            slot1_q.valid <= mem_slot1_i.valid;
        end
    end

    // payload follows the memory stage every cycle
    always_ff @(posedge clk) begin
        slot0_q.aluop    <= mem_slot0_i.aluop;
        slot0_q.excp     <= mem_slot0_i.excp;
        slot0_q.excp_num <= mem_slot0_i.excp_num;
        slot0_q.wb_reg   <= mem_slot0_i.wb_reg;
        slot1_q.aluop    <= mem_slot1_i.aluop;
        slot1_q.excp     <= mem_slot1_i.excp;
        slot1_q.excp_num <= mem_slot1_i.excp_num;
        slot1_q.wb_reg   <= mem_slot1_i.wb_reg;
    end

    assign wb_slot0_o = slot0_q;
    assign wb_slot1_o = slot1_q;

    // in-order issue never leaves slot 0 empty under slot 1
    a_slot_order: assert property (@(posedge clk) disable iff (rst)
        !(wb_slot1_o.valid && !wb_slot0_o.valid));

endmodule

// ==== include/pipeline_params.svh ====
`ifndef PIPELINE_PARAMS_SVH
`define PIPELINE_PARAMS_SVH

`define REG_BUS_W 32

// architectural exception codes
`define ECODE_INT  6'h00
`define ECODE_PIL  6'h01
`define ECODE_PIS  6'h02
`define ECODE_PIF  6'h03
`define ECODE_PME  6'h04
`define ECODE_PPI  6'h07
`define ECODE_ADEF 6'h08
`define ECODE_ALE  6'h09
`define ECODE_SYS  6'h0b
`define ECODE_BRK  6'h0c
`define ECODE_INE  6'h0d
`define ECODE_IPE  6'h0e
`define ECODE_TLBR 6'h3f

`define ESUBCODE_ADEF 9'd0
`define ESUBCODE_ADEM 9'd1

`define EXE_ERTN_OP 8'h4e

`define EENTRY_ADDR    32'h1c00_8000
`define TLBRENTRY_ADDR 32'h1c00_f000

// cause bit positions in excp_num, lowest wins
`define CAUSE_INT    4'd0
`define CAUSE_ADEF   4'd1
`define CAUSE_TLBR_F 4'd2
`define CAUSE_PIF    4'd3
`define CAUSE_PPI_F  4'd4
`define CAUSE_SYS    4'd5
`define CAUSE_BRK    4'd6
`define CAUSE_INE    4'd7
`define CAUSE_IPE    4'd8
`define CAUSE_ALE    4'd9
`define CAUSE_ADEM   4'd10
`define CAUSE_TLBR_M 4'd11
`define CAUSE_PME    4'd12
`define CAUSE_PPI_M  4'd13
`define CAUSE_PIS    4'd14
`define CAUSE_PIL    4'd15

`endif

// ==== verification/commit_tb.sv ====
`include "pipeline_params.svh"

module commit_tb
    import pipeline_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESP_TIMEOUT = 8;

    // stimulus columns first, then the expected response after the row
    typedef struct packed {
        wb_slot_t   s0;
        wb_slot_t   s1;
        logic       disp;
        logic [1:0] mstall;
        stall_t     stall;
        logic       c0;
        logic       c1;
        logic       flush;
        word_t      redirect;
        csr_state_t csr;
        word_t      rd0;
        word_t      rd1;
    } row_t;

    logic       clk;
    logic       rst;
    wb_slot_t   mem_slot0_i;
    wb_slot_t   mem_slot1_i;
    logic       dispatch_stallreq_i;
    logic [1:0] mem_stallreq_i;
    reg_addr_t  rf_raddr0_i;
    reg_addr_t  rf_raddr1_i;
    stall_t     stall_o;
    logic       flush_o;
    word_t      redirect_pc_o;
    commit_t    commit0_o;
    commit_t    commit1_o;
    csr_state_t csr_o;
    word_t      rf_rdata0_o;
    word_t      rf_rdata1_o;

    row_t       rows[$];
    word_t      ref_regs [32];
    csr_state_t ref_csr;

    commit_top UUT (
        .clk                 (clk),
        .rst                 (rst),
        .mem_slot0_i         (mem_slot0_i),
        .mem_slot1_i         (mem_slot1_i),
        .dispatch_stallreq_i (dispatch_stallreq_i),
        .mem_stallreq_i      (mem_stallreq_i),
        .rf_raddr0_i         (rf_raddr0_i),
        .rf_raddr1_i         (rf_raddr1_i),
        .stall_o             (stall_o),
        .flush_o             (flush_o),
        .redirect_pc_o       (redirect_pc_o),
        .commit0_o           (commit0_o),
        .commit1_o           (commit1_o),
        .csr_o               (csr_o),
        .rf_rdata0_o         (rf_rdata0_o),
        .rf_rdata1_o         (rf_rdata1_o)
    );

    always #5 clk = ~clk;

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic verify_csr(input csr_state_t exp);
        check(32'({csr_o.crmd_plv, csr_o.crmd_ie, csr_o.prmd_pplv, csr_o.prmd_pie}),
              32'({exp.crmd_plv, exp.crmd_ie, exp.prmd_pplv, exp.prmd_pie}), "crmd/prmd");
        check(csr_o.era, exp.era, "era");
        check(32'(csr_o.ecode), 32'(exp.ecode), "ecode");
        check(32'(csr_o.esubcode), 32'(exp.esubcode), "esubcode");
        check(csr_o.badv, exp.badv, "badv");
        check(32'(csr_o.vppn), 32'(exp.vppn), "vppn");
    endtask

    function automatic wb_slot_t make_slot(input logic valid, input aluop_t op,
                                           input excp_vec_t num, input reg_addr_t rd,
                                           input word_t data, input word_t pc);
        wb_slot_t s;
        s.valid         = valid;
        s.aluop         = op;
        s.excp          = |num;
        s.excp_num      = num;
        s.wb_reg.we     = 1'b1;
        s.wb_reg.waddr  = rd;
        s.wb_reg.wdata  = data;
        s.wb_reg.pc     = pc;
        return s;
    endfunction

    function automatic wb_slot_t plain_slot(input reg_addr_t rd, input word_t data,
                                            input word_t pc);
        return make_slot(1'b1, 8'h00, '0, rd, data, pc);
    endfunction

    function automatic wb_slot_t idle_slot();
        return make_slot(1'b0, 8'h00, '0, 5'd0, '0, '0);
    endfunction

    // ecode per cause bit, ADEM shares the ADE code
    function automatic ecode_t cause_ecode(input int c);
        case (c)
            0:       return `ECODE_INT;
            1, 10:   return `ECODE_ADEF;
            2, 11:   return `ECODE_TLBR;
            3:       return `ECODE_PIF;
            4, 13:   return `ECODE_PPI;
            5:       return `ECODE_SYS;
            6:       return `ECODE_BRK;
            7:       return `ECODE_INE;
            8:       return `ECODE_IPE;
            9:       return `ECODE_ALE;
            12:      return `ECODE_PME;
            14:      return `ECODE_PIS;
            default: return `ECODE_PIL;
        endcase
    endfunction

    task automatic add_row(input wb_slot_t s0, input wb_slot_t s1, input logic disp,
                           input logic [1:0] mstall);
        row_t r;
        r        = '0;
        r.s0     = s0;
        r.s1     = s1;
        r.disp   = disp;
        r.mstall = mstall;
        rows.push_back(r);
    endtask

    // reference model, advances ref_regs and ref_csr row by row
    task automatic fill_expected(inout row_t r);
        wb_slot_t s0;
        wb_slot_t s1;
        wb_slot_t sel;
        logic     ertn;
        logic     excp0;
        logic     excp1;
        logic     has_va;
        logic     tlb;
        word_t    bad_va;
        int       cause;
        s0 = r.s0;
        s1 = r.s1;
        r.stall = (r.mstall != 2'b00) ? 5'b11110 : (r.disp ? 5'b11100 : 5'b00000);
        // held memory stage arrives as a bubble
        if (r.stall[3]) begin
            s0.valid = 1'b0;
            s1.valid = 1'b0;
        end
        r.c0  = s0.valid && !s0.excp;
        ertn  = r.c0 && (s0.aluop == `EXE_ERTN_OP);
        r.c1  = s1.valid && !s1.excp && r.c0 && !ertn;
        excp0 = s0.valid && s0.excp;
        excp1 = s1.valid && s1.excp && r.c0 && !ertn;
        r.flush    = excp0 || excp1 || ertn;
        r.redirect = '0;
        if (excp0 || excp1) begin
            sel   = excp0 ? s0 : s1;
            cause = 0;
            while (!sel.excp_num[cause]) begin
                cause++;
            end
            has_va = !(cause == 0 || (cause >= 5 && cause <= 8));
            tlb    = (cause >= 2 && cause <= 4) || cause >= 11;
            bad_va = (cause <= 4) ? sel.wb_reg.pc : sel.wb_reg.wdata;
            r.redirect = (cause == 2 || cause == 11) ? `TLBRENTRY_ADDR : `EENTRY_ADDR;
            ref_csr.prmd_pplv = ref_csr.crmd_plv;
            ref_csr.prmd_pie  = ref_csr.crmd_ie;
            ref_csr.crmd_plv  = 2'd0;
            ref_csr.crmd_ie   = 1'b0;
            ref_csr.era       = sel.wb_reg.pc;
            ref_csr.ecode     = cause_ecode(cause);
            ref_csr.esubcode  = (cause == 10) ? `ESUBCODE_ADEM : `ESUBCODE_ADEF;
            if (has_va) begin
                ref_csr.badv = bad_va;
            end
            if (tlb) begin
                ref_csr.vppn = bad_va[31:13];
            end
        end else if (ertn) begin
            r.redirect       = ref_csr.era;
            ref_csr.crmd_plv = ref_csr.prmd_pplv;
            ref_csr.crmd_ie  = ref_csr.prmd_pie;
        end
        if (r.c0 && s0.wb_reg.we && s0.wb_reg.waddr != '0) begin
            ref_regs[s0.wb_reg.waddr] = s0.wb_reg.wdata;
        end
        // younger slot last
        if (r.c1 && s1.wb_reg.we && s1.wb_reg.waddr != '0) begin
            ref_regs[s1.wb_reg.waddr] = s1.wb_reg.wdata;
        end
        r.csr = ref_csr;
        r.rd0 = ref_regs[s0.wb_reg.waddr];
        r.rd1 = ref_regs[s1.wb_reg.waddr];
    endtask

    task automatic build_table();
        word_t pc;
        // fill r1..r31, the last slot 1 aims at r0
        for (int i = 0; i < 16; i++) begin
            pc = 32'h1c00_0000 + 32'(8 * i);
            add_row(plain_slot(5'(2 * i + 1), $urandom, pc),
                    plain_slot(5'((2 * i + 2) % 32), $urandom, pc + 32'd4), 1'b0, 2'b00);
        end
        add_row(plain_slot(5'd5, 32'h1111_1111, 32'h1c00_0100),
                plain_slot(5'd5, 32'h2222_2222, 32'h1c00_0104), 1'b0, 2'b00);
        add_row(plain_slot(5'd6, $urandom, 32'h1c00_0108),
                plain_slot(5'd7, $urandom, 32'h1c00_010c), 1'b1, 2'b00);
        add_row(plain_slot(5'd8, $urandom, 32'h1c00_0110),
                plain_slot(5'd9, $urandom, 32'h1c00_0114), 1'b0, 2'b01);
        add_row(plain_slot(5'd10, $urandom, 32'h1c00_0118),
                plain_slot(5'd11, $urandom, 32'h1c00_011c), 1'b1, 2'b10);
        // ALE, then fetch-side TLBR
        add_row(make_slot(1'b1, 8'h00, 16'h0200, 5'd10, 32'h0000_1003, 32'h1c00_0120),
                plain_slot(5'd11, 32'hdead_beef, 32'h1c00_0124), 1'b0, 2'b00);
        add_row(make_slot(1'b1, 8'h00, 16'h0004, 5'd12, 32'h0, 32'h8040_6ffc),
                plain_slot(5'd13, 32'h5555_5555, 32'h8040_7000), 1'b0, 2'b00);
        // ADEM in slot 1 behind a clean slot 0
        add_row(plain_slot(5'd14, 32'h3333_3333, 32'h1c00_0130),
                make_slot(1'b1, 8'h00, 16'h0400, 5'd15, 32'hbfff_fff8, 32'h1c00_0134),
                1'b0, 2'b00);
        // SYS, INE and PME pending in slot 0, PIL in slot 1
        add_row(make_slot(1'b1, 8'h00, 16'h10a0, 5'd16, 32'h0bad_0000, 32'h1c00_0140),
                make_slot(1'b1, 8'h00, 16'h8000, 5'd17, 32'h0bad_1000, 32'h1c00_0144),
                1'b0, 2'b00);
        add_row(make_slot(1'b1, 8'h00, 16'h6800, 5'd18, 32'h7fff_e010, 32'h1c00_0150),
                idle_slot(), 1'b0, 2'b00);
        add_row(make_slot(1'b1, `EXE_ERTN_OP, '0, 5'd0, 32'h0, 32'h1c00_0160),
                plain_slot(5'd19, 32'h4444_4444, 32'h1c00_0164), 1'b0, 2'b00);
        add_row(make_slot(1'b1, 8'h00, 16'h0001, 5'd20, 32'h0, 32'h1c00_0170),
                idle_slot(), 1'b0, 2'b00);
        add_row(make_slot(1'b1, 8'h00, 16'h0008, 5'd20, 32'h0, 32'h0040_2468),
                idle_slot(), 1'b0, 2'b00);
        add_row(plain_slot(5'd21, $urandom, 32'h1c00_0180),
                plain_slot(5'd22, $urandom, 32'h1c00_0184), 1'b0, 2'b00);
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   waited;
        r = rows[idx];
        mem_slot0_i         = r.s0;
        mem_slot1_i         = r.s1;
        dispatch_stallreq_i = r.disp;
        mem_stallreq_i      = r.mstall;
        #4;
        check(32'(stall_o), 32'(r.stall), "stall vector");
        @(posedge clk);
        #1;
        mem_slot0_i         = idle_slot();
        mem_slot1_i         = idle_slot();
        dispatch_stallreq_i = 1'b0;
        mem_stallreq_i      = 2'b00;
        rf_raddr0_i         = r.s0.wb_reg.waddr;
        rf_raddr1_i         = r.s1.wb_reg.waddr;
        #4;
        waited = 0;
        if (r.c0 || r.flush) begin
            while (!(commit0_o.valid || flush_o)) begin
                if (waited == RESP_TIMEOUT) begin
                    $display("timeout: row %0d never committed or flushed", idx);
                    $display("Done: errors found");
                    $fatal(1, "response timeout");
                end else begin
                    @(posedge clk);
                    #5;
                    waited++;
                end
            end
        end
        check(32'(waited), 32'd0, "extra cycles before retirement");
        check(32'(commit0_o.valid), 32'(r.c0), "commit0 valid");
        check(32'(commit1_o.valid), 32'(r.c1), "commit1 valid");
        check(32'(flush_o), 32'(r.flush), "flush");
        if (r.c0) begin
            check(commit0_o.pc, r.s0.wb_reg.pc, "commit0 pc");
        end
        if (r.c1) begin
            check(commit1_o.pc, r.s1.wb_reg.pc, "commit1 pc");
        end
        if (r.flush) begin
            check(redirect_pc_o, r.redirect, "redirect target");
        end
        // csr and register file settle one edge later
        @(posedge clk);
        #4;
        verify_csr(r.csr);
        check(rf_rdata0_o, r.rd0, "register read port 0");
        check(rf_rdata1_o, r.rd1, "register read port 1");
        @(posedge clk);
        #1;
    endtask

    initial begin
        row_t r;
        void'($urandom(32'he8f7_dc86));
        clk                 = 1'b0;
        rst                 = 1'b1;
        mem_slot0_i         = idle_slot();
        mem_slot1_i         = idle_slot();
        dispatch_stallreq_i = 1'b0;
        mem_stallreq_i      = 2'b00;
        rf_raddr0_i         = '0;
        rf_raddr1_i         = '0;
        ref_csr             = '0;
        for (int k = 0; k < 32; k++) begin
            ref_regs[k] = '0;
        end
        build_table();
        foreach (rows[k]) begin
            r = rows[k];
            fill_expected(r);
            rows[k] = r;
        end
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        #4;
        // quiet pipeline straight out of reset
        check(32'(stall_o), 32'd0, "stall after reset");
        check(32'(flush_o), 32'd0, "flush after reset");
        check(32'(commit0_o.valid), 32'd0, "commit0 after reset");
        check(32'(commit1_o.valid), 32'd0, "commit1 after reset");
        verify_csr('0);
        @(posedge clk);
        #1;
        foreach (rows[k]) begin
            run_row(k);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule
